// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator, output in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module GpioDisplay_tb -f src.f
	./obj_dir/VGpioDisplay_tb 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: src.f
src/gpioPkg.sv
src/segFrameIf.sv
src/GpioApbRegs.sv
src/SegFrameBuffer.sv
src/SegScanDriver.sv
src/GpioDisplayTop.sv
tb/GpioDisplay_checker.sv
tb/GpioDisplay_tb.sv

// File: src/GpioApbRegs.sv
`timescale 1ns/1ns

module GpioApbRegs (
    input  logic                i_Clk,
    input  logic                i_arstN,

    input  logic                i_Psel,
    input  logic                i_Penable,
    input  logic                i_Pwrite,
    input  gpioPkg::regAddr_t   i_Paddr,
    input  gpioPkg::busData_t   i_Pwdata,
    input  logic [3:0]          i_Pstrb,
    output gpioPkg::busData_t   o_Prdata,
    output logic                o_Pready,
    output logic                o_Pslverr,

    input  gpioPkg::gpioWord_t  i_GpioIn,
    output gpioPkg::gpioWord_t  o_GpioOut,
    output gpioPkg::gpioWord_t  o_GpioOe,

    segFrameIf.producer         o_frame
);

    logic accessPhase;
    logic addrHit;
    logic slvErr;
    logic wrEn;

    gpioPkg::gpioWord_t inSync1;
    gpioPkg::gpioWord_t inSync2;
    gpioPkg::gpioWord_t outReg;
    gpioPkg::gpioWord_t ddrReg;
    gpioPkg::gpioWord_t outPin;
    gpioPkg::gpioWord_t oePin;

    gpioPkg::segPattern_t [gpioPkg::NUM_DIGITS-1:0] segDigits;
    logic                                           segLutEn;
    logic                                           segLoad;

    gpioPkg::busData_t segWord;
    gpioPkg::busData_t rdMux;

    assign accessPhase = i_Psel & i_Penable;
    assign o_Pready    = 1'b1;              // no wait states

    always_comb begin
        segWord = '0;
        for (int d = 0; d < gpioPkg::NUM_DIGITS; d++) begin
            segWord[8*d +: 7] = segDigits[d];
        end
        segWord[8*gpioPkg::NUM_DIGITS] = segLutEn;
    end

    always_comb begin
        addrHit = 1'b1;
        rdMux   = '0;
        case (i_Paddr)
            gpioPkg::REG_GPIO_IN:  rdMux = gpioPkg::busData_t'(inSync2);
            gpioPkg::REG_GPIO_OUT: rdMux = gpioPkg::busData_t'(outReg);
            gpioPkg::REG_GPIO_DDR: rdMux = gpioPkg::busData_t'(ddrReg);
            gpioPkg::REG_7SEG:     rdMux = segWord;
            default:               addrHit = 1'b0;
        endcase
    end

    // unmapped address, or a write to the input register
    assign slvErr = ~addrHit | (i_Pwrite & (i_Paddr == gpioPkg::REG_GPIO_IN));
    assign wrEn   = accessPhase & i_Pwrite & ~slvErr;

    assign o_Pslverr = accessPhase & slvErr;
    assign o_Prdata  = rdMux;

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            inSync1   <= '0;
            inSync2   <= '0;
            outReg    <= '0;
            ddrReg    <= '0;
            outPin    <= '0;
            oePin     <= '0;
            segDigits <= '0;
            segLutEn  <= 1'b0;
            segLoad   <= 1'b0;
        end else begin
            inSync1 <= i_GpioIn;            // two-flop synchronizer
            inSync2 <= inSync1;
            outPin  <= outReg;
            oePin   <= ddrReg;
            segLoad <= 1'b0;

            if (wrEn) begin
                case (i_Paddr)
                    gpioPkg::REG_GPIO_OUT: begin
                        if (i_Pstrb[0]) begin
                            outReg <= i_Pwdata[7:0];
                        end
                    end
                    gpioPkg::REG_GPIO_DDR: begin
                        if (i_Pstrb[0]) begin
                            ddrReg <= i_Pwdata[7:0];
                        end
                    end
                    gpioPkg::REG_7SEG: begin
                        for (int d = 0; d < gpioPkg::NUM_DIGITS; d++) begin
                            if (i_Pstrb[d]) begin
                                segDigits[d] <= i_Pwdata[8*d +: 7];
                            end
                        end
                        if (i_Pstrb[gpioPkg::NUM_DIGITS]) begin
                            segLutEn <= i_Pwdata[8*gpioPkg::NUM_DIGITS];
                        end
                        segLoad <= 1'b1;    // even with no strobe set
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign o_GpioOut = outPin;
    assign o_GpioOe  = oePin;

    assign o_frame.digits = segDigits;
    assign o_frame.lutEn  = segLutEn;
    assign o_frame.load   = segLoad;

endmodule

// File: src/GpioDisplayTop.sv
`timescale 1ns/1ns

module GpioDisplayTop (
    input  logic                 i_Clk,
    input  logic                 i_arstN,

    // apb slave
    input  logic                 i_Psel,
    input  logic                 i_Penable,
    input  logic                 i_Pwrite,
    input  gpioPkg::regAddr_t    i_Paddr,
    input  gpioPkg::busData_t    i_Pwdata,
    input  logic [3:0]           i_Pstrb,
    output gpioPkg::busData_t    o_Prdata,
    output logic                 o_Pready,
    output logic                 o_Pslverr,

    // gpio port
    input  gpioPkg::gpioWord_t   i_GpioIn,
    output gpioPkg::gpioWord_t   o_GpioOut,
    output gpioPkg::gpioWord_t   o_GpioOe,

    // 7 segment display
    output gpioPkg::digitSel_t   o_SegEn,
    output gpioPkg::segPattern_t o_SegLed
);

    segFrameIf  segFrame ();
    scanFrameIf scanFrame ();

    GpioApbRegs apbRegs (
        .i_Clk     (i_Clk),
        .i_arstN   (i_arstN),
        .i_Psel    (i_Psel),
        .i_Penable (i_Penable),
        .i_Pwrite  (i_Pwrite),
        .i_Paddr   (i_Paddr),
        .i_Pwdata  (i_Pwdata),
        .i_Pstrb   (i_Pstrb),
        .o_Prdata  (o_Prdata),
        .o_Pready  (o_Pready),
        .o_Pslverr (o_Pslverr),
        .i_GpioIn  (i_GpioIn),
        .o_GpioOut (o_GpioOut),
        .o_GpioOe  (o_GpioOe),
        .o_frame   (segFrame.producer)
    );

    SegFrameBuffer frameBuffer (
        .i_Clk   (i_Clk),
        .i_arstN (i_arstN),
        .i_frame (segFrame.consumer),
        .o_scan  (scanFrame.source)
    );

    SegScanDriver scanDriver (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_scan   (scanFrame.sink),
        .o_SegEn  (o_SegEn),
        .o_SegLed (o_SegLed)
    );

endmodule

// File: src/SegFrameBuffer.sv
`timescale 1ns/1ns

module SegFrameBuffer (
    input  logic        i_Clk,
    input  logic        i_arstN,

    segFrameIf.consumer i_frame,
    scanFrameIf.source  o_scan
);

    gpioPkg::segPattern_t [gpioPkg::NUM_DIGITS-1:0] pendDigits;
    gpioPkg::segPattern_t [gpioPkg::NUM_DIGITS-1:0] dispDigits;

    logic pendLutEn;
    logic pendValid;
    logic dispLutEn;
    logic promote;

    // a frame loaded in the same cycle as frameStart waits for the next one
    assign promote = o_scan.frameStart & pendValid;

    always_ff @(posedge i_Clk) begin
        if (i_frame.load) begin
            pendDigits <= i_frame.digits;   // later load overwrites
            pendLutEn  <= i_frame.lutEn;
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pendValid  <= 1'b0;
            dispDigits <= '0;
            dispLutEn  <= 1'b0;
        end else begin
            if (promote) begin
                dispDigits <= pendDigits;
                dispLutEn  <= pendLutEn;
            end

            if (i_frame.load) begin
                pendValid <= 1'b1;
            end else if (promote) begin
                pendValid <= 1'b0;
            end
        end
    end

    assign o_scan.digits = dispDigits;
    assign o_scan.lutEn  = dispLutEn;

endmodule

// File: src/SegScanDriver.sv
`timescale 1ns/1ns

module SegScanDriver (
    input  logic                 i_Clk,
    input  logic                 i_arstN,

    scanFrameIf.sink             i_scan,

    output gpioPkg::digitSel_t   o_SegEn,
    output gpioPkg::segPattern_t o_SegLed
);

    logic [gpioPkg::SCAN_DIV_BITS-1:0] divCnt;
    logic                              scanTick;

    gpioPkg::scanState_t  state;
    gpioPkg::scanState_t  stateNext;
    gpioPkg::segPattern_t rawPattern;

    // hex digit to segments, bit order g..a
    function automatic gpioPkg::segPattern_t hexToSeg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    hexToSeg = 7'h3F;
            4'h1:    hexToSeg = 7'h06;
            4'h2:    hexToSeg = 7'h5B;
            4'h3:    hexToSeg = 7'h4F;
            4'h4:    hexToSeg = 7'h66;
            4'h5:    hexToSeg = 7'h6D;
            4'h6:    hexToSeg = 7'h7D;
            4'h7:    hexToSeg = 7'h07;
            4'h8:    hexToSeg = 7'h7F;
            4'h9:    hexToSeg = 7'h6F;
            4'hA:    hexToSeg = 7'h77;
            4'hB:    hexToSeg = 7'h7C;
            4'hC:    hexToSeg = 7'h39;
            4'hD:    hexToSeg = 7'h5E;
            4'hE:    hexToSeg = 7'h79;
            default: hexToSeg = 7'h71;  // F
        endcase
    endfunction

    assign scanTick          = &divCnt;
    assign i_scan.frameStart = scanTick & (state == gpioPkg::DIG2);

    always_comb begin
        case (state)
            gpioPkg::DIG0: stateNext = gpioPkg::DIG1;
            gpioPkg::DIG1: stateNext = gpioPkg::DIG2;
            default:       stateNext = gpioPkg::DIG0;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            divCnt <= '0;
            state  <= gpioPkg::DIG0;
        end else begin
            divCnt <= divCnt + 1'b1;        // free running, wraps every 16
            if (scanTick) begin
                state <= stateNext;
            end
        end
    end

    always_comb begin
        case (state)
            gpioPkg::DIG1: begin
                o_SegEn    = 3'b010;
                rawPattern = i_scan.digits[1];
            end
            gpioPkg::DIG2: begin
                o_SegEn    = 3'b100;
                rawPattern = i_scan.digits[2];
            end
            default: begin
                o_SegEn    = 3'b001;
                rawPattern = i_scan.digits[0];
            end
        endcase
    end

    assign o_SegLed = i_scan.lutEn ? hexToSeg(rawPattern[3:0]) : rawPattern;

endmodule

// File: src/gpioPkg.sv
package gpioPkg;

    localparam int NUM_DIGITS = 3;           // digits on the display

    typedef logic [7:0]            gpioWord_t;   // one gpio port value
    typedef logic [31:0]           busData_t;    // apb data word
    typedef logic [3:0]            regAddr_t;    // byte address in the peripheral
    typedef logic [6:0]            segPattern_t; // segments a..g, a is bit 0
    typedef logic [NUM_DIGITS-1:0] digitSel_t;   // one-hot digit enable

    // register map
    localparam regAddr_t REG_GPIO_IN  = 4'h0;    // read only, synchronized pins
    localparam regAddr_t REG_GPIO_OUT = 4'h4;
    localparam regAddr_t REG_GPIO_DDR = 4'h8;    // 1 = pin driven
    localparam regAddr_t REG_7SEG     = 4'hC;

    localparam int SCAN_DIV_BITS = 4;            // scan tick every 2**4 clocks

    typedef enum logic [1:0] {
        DIG0,
        DIG1,
        DIG2
    } scanState_t;

endpackage

// File: src/segFrameIf.sv
`timescale 1ns/1ns

// register block to frame buffer
interface segFrameIf;
    gpioPkg::segPattern_t [gpioPkg::NUM_DIGITS-1:0] digits;
    logic                                           lutEn;
    logic                                           load;   // one cycle, data valid with it

    modport producer (output digits, output lutEn, output load);
    modport consumer (input digits, input lutEn, input load);
endinterface

// frame buffer to scanner
interface scanFrameIf;
    gpioPkg::segPattern_t [gpioPkg::NUM_DIGITS-1:0] digits;
    logic                                           lutEn;
    logic                                           frameStart; // wrap from DIG2 to DIG0

    modport source (output digits, output lutEn, input frameStart);
    modport sink (input digits, input lutEn, output frameStart);
endinterface

// File: tb/GpioDisplay_checker.sv
`timescale 1ns/1ns

module GpioDisplay_checker (
    input logic               i_Clk,
    input logic               i_arstN,
    input logic               i_Psel,
    input logic               i_Penable,
    input logic               i_Pready,
    input logic               i_Pslverr,
    input gpioPkg::digitSel_t i_SegEn
);

    logic [gpioPkg::SCAN_DIV_BITS-1:0] clkPhase;   // follows the scan divider
    int                                failCnt = 0;

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            clkPhase <= '0;
        end else begin
            clkPhase <= clkPhase + 1'b1;
        end
    end

    segEnOneHot: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        $onehot(i_SegEn))
        else begin
            $error("digit enable not one-hot: %b", i_SegEn);
            failCnt++;
        end

    readyWithSel: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_Psel |-> i_Pready)
        else begin
            $error("pready low while psel high");
            failCnt++;
        end

    errOnlyInAccess: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_Pslverr |-> (i_Psel && i_Penable))
        else begin
            $error("pslverr high outside an access cycle");
            failCnt++;
        end

    // a digit change shows up one sample after the divider wrap
    segEnOnBoundary: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        $changed(i_SegEn) |-> (clkPhase == '0))
        else begin
            $error("digit enable changed off a scan boundary");
            failCnt++;
        end

endmodule

// File: tb/GpioDisplay_tb.sv
`timescale 1ns/1ns

module GpioDisplay_tb;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_PINS,
        OP_DRIVE,
        OP_DISPLAY,
        OP_MIDFRAME
    } opCode_t;

    typedef struct packed {
        opCode_t           op;
        gpioPkg::regAddr_t addr;
        gpioPkg::busData_t data;
        logic [3:0]        strb;
        gpioPkg::busData_t expData;
        gpioPkg::busData_t prevData;    // pins or shown frame before the step
        logic              expErr;
    } step_t;

    logic                 clk = 1'b0;
    logic                 arstN;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    gpioPkg::regAddr_t    paddr;
    gpioPkg::busData_t    pwdata;
    logic [3:0]           pstrb;
    gpioPkg::busData_t    prdata;
    logic                 pready;
    logic                 pslverr;
    gpioPkg::gpioWord_t   gpioIn;
    gpioPkg::gpioWord_t   gpioOut;
    gpioPkg::gpioWord_t   gpioOe;
    gpioPkg::digitSel_t   segEn;
    gpioPkg::segPattern_t segLed;

    step_t                steps[$];
    gpioPkg::gpioWord_t   mIn = '0;         // register model, reset values
    gpioPkg::gpioWord_t   mOut = '0;
    gpioPkg::gpioWord_t   mDdr = '0;
    gpioPkg::busData_t    mSeg = '0;
    gpioPkg::busData_t    prevPins = '0;
    int                   errCnt = 0;
    int                   checkCnt = 0;
    int                   cycleCnt = 0;
    int                   cycleLimit = 0;

    // hex font, segment a in bit 0
    gpioPkg::segPattern_t segFont [0:15] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
        7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    GpioDisplayTop i_dut (
        .i_Clk     (clk),
        .i_arstN   (arstN),
        .i_Psel    (psel),
        .i_Penable (penable),
        .i_Pwrite  (pwrite),
        .i_Paddr   (paddr),
        .i_Pwdata  (pwdata),
        .i_Pstrb   (pstrb),
        .o_Prdata  (prdata),
        .o_Pready  (pready),
        .o_Pslverr (pslverr),
        .i_GpioIn  (gpioIn),
        .o_GpioOut (gpioOut),
        .o_GpioOe  (gpioOe),
        .o_SegEn   (segEn),
        .o_SegLed  (segLed)
    );

    bind GpioDisplayTop GpioDisplay_checker protoCheck (
        .i_Clk     (i_Clk),
        .i_arstN   (i_arstN),
        .i_Psel    (i_Psel),
        .i_Penable (i_Penable),
        .i_Pready  (o_Pready),
        .i_Pslverr (o_Pslverr),
        .i_SegEn   (o_SegEn)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleLimit != 0 && cycleCnt >= cycleLimit) begin
            $display("test timed out after %0d cycles", cycleCnt);
            errCnt++;
            errCnt += i_dut.protoCheck.failCnt;
            $display("errors: %0d, checks: %0d", errCnt, checkCnt);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic isMapped(input gpioPkg::regAddr_t addr);
        return addr inside {gpioPkg::REG_GPIO_IN, gpioPkg::REG_GPIO_OUT,
                            gpioPkg::REG_GPIO_DDR, gpioPkg::REG_7SEG};
    endfunction

    // what the pins show for a register word, digit d in lane d
    function automatic gpioPkg::busData_t displayOf(input gpioPkg::busData_t segWord);
        gpioPkg::busData_t    shown;
        gpioPkg::segPattern_t pat;
        shown = '0;
        for (int d = 0; d < gpioPkg::NUM_DIGITS; d++) begin
            pat = segWord[8*d +: 7];
            if (segWord[24]) begin
                pat = segFont[pat[3:0]];
            end
            shown[8*d +: 7] = pat;
        end
        return shown;
    endfunction

    function automatic int digitIdx(input gpioPkg::digitSel_t sel);
        for (int d = 0; d < gpioPkg::NUM_DIGITS; d++) begin
            if (sel[d]) begin
                return d;
            end
        end
        return 0;
    endfunction

    function automatic gpioPkg::busData_t modelRead(input gpioPkg::regAddr_t addr);
        case (addr)
            gpioPkg::REG_GPIO_IN:  return {24'h0, mIn};
            gpioPkg::REG_GPIO_OUT: return {24'h0, mOut};
            gpioPkg::REG_GPIO_DDR: return {24'h0, mDdr};
            gpioPkg::REG_7SEG:     return mSeg;
            default:               return '0;
        endcase
    endfunction

    function automatic void pushStep(input opCode_t op, input gpioPkg::regAddr_t addr,
                                     input gpioPkg::busData_t data, input logic [3:0] strb,
                                     input gpioPkg::busData_t expData,
                                     input gpioPkg::busData_t prevData, input logic expErr);
        steps.push_back('{op, addr, data, strb, expData, prevData, expErr});
    endfunction

    function automatic void addWrite(input gpioPkg::regAddr_t addr,
                                     input gpioPkg::busData_t data, input logic [3:0] strb);
        logic err;
        err = !isMapped(addr) || addr == gpioPkg::REG_GPIO_IN;
        prevPins = {16'h0, mDdr, mOut};
        if (!err && strb[0] && addr == gpioPkg::REG_GPIO_OUT) begin
            mOut = data[7:0];
        end
        if (!err && strb[0] && addr == gpioPkg::REG_GPIO_DDR) begin
            mDdr = data[7:0];
        end
        if (addr == gpioPkg::REG_7SEG) begin
            for (int l = 0; l < gpioPkg::NUM_DIGITS; l++) begin
                if (strb[l]) begin
                    mSeg[8*l +: 7] = data[8*l +: 7];
                end
            end
            if (strb[3]) begin
                mSeg[24] = data[24];    // lutEn
            end
        end
        pushStep(OP_WRITE, addr, data, strb, '0, '0, err);
    endfunction

    function automatic void addRead(input gpioPkg::regAddr_t addr);
        pushStep(OP_READ, addr, '0, 4'h0, modelRead(addr), '0, !isMapped(addr));
    endfunction

    function automatic void addPins();
        pushStep(OP_PINS, '0, '0, 4'h0, {16'h0, mDdr, mOut}, prevPins, 1'b0);
        prevPins = {16'h0, mDdr, mOut};
    endfunction

    function automatic void addDrive(input gpioPkg::gpioWord_t value);
        mIn = value;
        pushStep(OP_DRIVE, '0, {24'h0, value}, 4'h0, '0, '0, 1'b0);
    endfunction

    function automatic void addMidFrame(input gpioPkg::busData_t data);
        gpioPkg::busData_t oldShown;
        oldShown = displayOf(mSeg);
        mSeg     = data & 32'h017F_7F7F;
        pushStep(OP_MIDFRAME, gpioPkg::REG_7SEG, data, 4'hF, displayOf(mSeg), oldShown, 1'b0);
    endfunction

    function automatic void buildTable();
        for (int i = 0; i < 4; i++) begin
            addWrite(gpioPkg::REG_GPIO_OUT, $urandom, {3'($urandom), 1'(i)});
            addPins();
            addRead(gpioPkg::REG_GPIO_OUT);
            addWrite(gpioPkg::REG_GPIO_DDR, $urandom, {3'($urandom), 1'(i + 1)});
            addPins();
            addRead(gpioPkg::REG_GPIO_DDR);
        end
        for (int i = 0; i < 4; i++) begin
            addDrive(8'($urandom));
            addRead(gpioPkg::REG_GPIO_IN);
        end
        addWrite(gpioPkg::REG_7SEG, $urandom, 4'hF);
        addRead(gpioPkg::REG_7SEG);
        for (int l = 0; l < 4; l++) begin
            addWrite(gpioPkg::REG_7SEG, $urandom, 4'(1 << l));
            addRead(gpioPkg::REG_7SEG);
        end
        for (int i = 0; i < 2; i++) begin
            addWrite(gpioPkg::REG_7SEG, $urandom & 32'h00FF_FFFF, 4'hF);
            addDisplay();
            addWrite(gpioPkg::REG_7SEG, $urandom | 32'h0100_0000, 4'hF);
            addDisplay();
        end
        addMidFrame($urandom);
        addDisplay();
        addWrite(4'h2, $urandom, 4'hF);     // unmapped
        addWrite(4'hD, $urandom, 4'hF);
        addWrite(gpioPkg::REG_GPIO_IN, $urandom, 4'hF);
        addRead(4'h6);
        addPins();
        addRead(gpioPkg::REG_GPIO_IN);
        addRead(gpioPkg::REG_GPIO_OUT);
        addRead(gpioPkg::REG_GPIO_DDR);
        addRead(gpioPkg::REG_7SEG);
    endfunction

    function automatic void addDisplay();
        pushStep(OP_DISPLAY, '0, '0, 4'h0, displayOf(mSeg), '0, 1'b0);
    endfunction

    task automatic checkEq(input gpioPkg::busData_t got, input gpioPkg::busData_t exp,
                           input string msg);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("FAILED @%0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // setup then access cycle, returns at the edge that ends the access
    task automatic apbAccess(input logic wr, input gpioPkg::regAddr_t addr,
                             input gpioPkg::busData_t data, input logic [3:0] strb,
                             output gpioPkg::busData_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        checkEq(pready, 1, "pready in access cycle");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // a load needs two clocks to reach the pending frame
    task automatic waitFrameStart();
        gpioPkg::digitSel_t prev;
        @(posedge clk);
        @(negedge clk);
        prev = segEn;
        @(negedge clk);
        while (!(prev == 3'b100 && segEn == 3'b001)) begin
            prev = segEn;
            @(negedge clk);
        end
    endtask

    task automatic runStep(input step_t s);
        gpioPkg::busData_t  rdata;
        logic               err;
        gpioPkg::digitSel_t prev;
        int                 cnt;
        case (s.op)
            OP_WRITE: begin
                apbAccess(1'b1, s.addr, s.data, s.strb, rdata, err);
                checkEq(err, s.expErr, $sformatf("pslverr on write to %h", s.addr));
            end
            OP_READ: begin
                apbAccess(1'b0, s.addr, '0, 4'h0, rdata, err);
                checkEq(rdata, s.expData, $sformatf("read data at %h", s.addr));
                checkEq(err, s.expErr, $sformatf("pslverr on read of %h", s.addr));
            end
            OP_PINS: begin
                @(negedge clk);
                checkEq({gpioOe, gpioOut}, s.prevData, "pins in the write edge cycle");
                @(negedge clk);
                checkEq({gpioOe, gpioOut}, s.expData, "pins one clock after write");
            end
            OP_DRIVE: begin
                @(posedge clk);
                gpioIn <= s.data[7:0];
                repeat (2) @(posedge clk);  // synchronizer depth
            end
            OP_DISPLAY: begin
                waitFrameStart();
                for (int d = 0; d < gpioPkg::NUM_DIGITS; d++) begin
                    while (segEn != gpioPkg::digitSel_t'(1 << d)) begin
                        @(negedge clk);
                    end
                    checkEq(segLed, s.expData[8*d +: 7], $sformatf("digit %0d pattern", d));
                end
            end
            default: begin
                do begin
                    @(negedge clk);
                end while (segEn != 3'b010);
                apbAccess(1'b1, s.addr, s.data, s.strb, rdata, err);
                @(negedge clk);
                prev = segEn;
                cnt  = 0;
                while (!(prev == 3'b100 && segEn == 3'b001)) begin
                    checkEq(segLed, s.prevData[8*digitIdx(segEn) +: 7], "old frame in scan");
                    prev = segEn;
                    @(negedge clk);
                    cnt++;
                end
                checkEq(cnt <= 3 * 16 + 2, 1, "new frame latency");
                checkEq(segLed, s.expData[6:0], "new frame at DIG0");
            end
        endcase
    endtask

    initial begin
        arstN   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = 4'h0;
        gpioIn  = '0;
        void'($urandom(41228));
        buildTable();
        cycleLimit = steps.size() * 120;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkEq(segEn, 3'b001, "digit enable after reset");
        checkEq(segLed, 0, "segments after reset");
        checkEq({gpioOe, gpioOut}, 0, "gpio pins after reset");
        checkEq(pslverr, 0, "pslverr while idle");
        foreach (steps[i]) begin
            runStep(steps[i]);
        end
        @(posedge clk);
        errCnt += i_dut.protoCheck.failCnt;    // assertion failures in the bound checker
        $display("errors: %0d, checks: %0d", errCnt, checkCnt);
        if (errCnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
